// File: list.f
src/dispatch_pkg.sv
src/dispatch_ctrl_regs.sv
src/dispatch_operand_regs.sv
src/dispatch_mem_regs.sv
src/dispatch_pipe.sv
testbench/tb_dispatch_pipe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dispatch pipeline testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_dispatch_pipe -f list.f -o sim_dispatch_pipe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_dispatch_pipe > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $LOG"
exit 1

// File: src/dispatch_ctrl_regs.sv
// stall and flush decode plus the flushable valid, request, sys-op and exception registers
`timescale 1ns/1ns

module dispatch_ctrl_regs
    import dispatch_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [CU_BUS_W-1:0] stall_flag_i,

    input  logic                inst_valid_i,
    input  logic                req_alu_i,
    input  logic                req_bjp_i,
    input  logic                req_mem_i,
    input  logic                illegal_inst_i,
    input  logic                misaligned_load_i,
    input  logic                misaligned_store_i,
    input  logic [SYS_OP_W-1:0] sys_op_i,

    output logic                upd_en_o,          // load enable for the payload slices
    output logic                inst_valid_o,
    output logic                req_alu_o,
    output logic                req_bjp_o,
    output logic                req_mem_o,
    output logic                illegal_inst_o,
    output logic                misaligned_load_o,
    output logic                misaligned_store_o,
    output logic [SYS_OP_W-1:0] sys_op_o
);

    // nop is the one sys op a flush leaves alone
    localparam logic [SYS_OP_W-1:0] SYS_KEEP_MASK = SYS_OP_W'(1) << SYS_NOP;

    logic                flush_en;
    logic [SYS_OP_W-1:0] sys_op_nxt;

    // agu stall kills the item just like a flush
    assign flush_en = stall_flag_i[CU_FLUSH] | stall_flag_i[CU_STALL_AGU];
    assign upd_en_o = ~stall_flag_i[CU_STALL_DISPATCH];

    always_comb begin
        sys_op_nxt = sys_op_i;
        if (flush_en) begin
            sys_op_nxt = sys_op_i & SYS_KEEP_MASK;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_o       <= 1'b0;
            req_alu_o          <= 1'b0;
            req_bjp_o          <= 1'b0;
            req_mem_o          <= 1'b0;
            illegal_inst_o     <= 1'b0;
            misaligned_load_o  <= 1'b0;
            misaligned_store_o <= 1'b0;
            sys_op_o           <= '0;
        end else if (upd_en_o) begin  // dispatch stall masks any flush
            inst_valid_o       <= inst_valid_i & ~flush_en;
            req_alu_o          <= req_alu_i & ~flush_en;
            req_bjp_o          <= req_bjp_i & ~flush_en;
            req_mem_o          <= req_mem_i & ~flush_en;
            // exceptions of a killed item must not reach commit
            illegal_inst_o     <= illegal_inst_i & ~flush_en;
            misaligned_load_o  <= misaligned_load_i & ~flush_en;
            misaligned_store_o <= misaligned_store_i & ~flush_en;
            sys_op_o           <= sys_op_nxt;
        end
    end

endmodule

// File: src/dispatch_mem_regs.sv
// memory access description registers and the shared bjp/mem op word
`timescale 1ns/1ns

module dispatch_mem_regs
    import dispatch_pkg::*;
#(
    parameter int COMMIT_ID_W = 3,
    parameter int MEM_DATA_W  = 64
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    upd_en_i,

    input  logic [XLEN-1:0]         mem_addr_i,
    input  logic [MEM_DATA_W/8-1:0] mem_wmask_i,
    input  logic [MEM_DATA_W-1:0]   mem_wdata_i,
    input  logic [COMMIT_ID_W-1:0]  mem_commit_id_i,
    input  logic [REG_ADDR_W-1:0]   mem_reg_waddr_i,
    input  fu_op_u                  fu_op_i,

    output logic [XLEN-1:0]         mem_addr_o,
    output logic [MEM_DATA_W/8-1:0] mem_wmask_o,
    output logic [MEM_DATA_W-1:0]   mem_wdata_o,
    output logic [COMMIT_ID_W-1:0]  mem_commit_id_o,
    output logic [REG_ADDR_W-1:0]   mem_reg_waddr_o,
    output fu_op_u                  fu_op_o          // bjp unit and lsu read their own view
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_addr_o      <= '0;
            mem_wmask_o     <= '0;
            mem_wdata_o     <= '0;
            mem_commit_id_o <= '0;
            mem_reg_waddr_o <= '0;
            fu_op_o         <= '0;
        end else if (upd_en_i) begin
            mem_addr_o      <= mem_addr_i;   // already computed by the agu
            mem_wmask_o     <= mem_wmask_i;
            mem_wdata_o     <= mem_wdata_i;  // lane aligned store data
            // the lsu writes back under its own id
            mem_commit_id_o <= mem_commit_id_i;
            mem_reg_waddr_o <= mem_reg_waddr_i;
            fu_op_o         <= fu_op_i;
        end
    end

endmodule

// File: src/dispatch_operand_regs.sv
// enable-gated register bank for instruction info, alu operands and bjp operands
`timescale 1ns/1ns

module dispatch_operand_regs
    import dispatch_pkg::*;
#(
    parameter int COMMIT_ID_W = 3
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   upd_en_i,

    input  logic [XLEN-1:0]        inst_i,
    input  logic [XLEN-1:0]        inst_addr_i,
    input  logic [COMMIT_ID_W-1:0] commit_id_i,
    input  logic                   reg_we_i,
    input  logic [REG_ADDR_W-1:0]  reg_waddr_i,
    input  logic [XLEN-1:0]        alu_op1_i,
    input  logic [XLEN-1:0]        alu_op2_i,
    input  logic [ALU_OP_W-1:0]    alu_op_info_i,
    input  logic [XLEN-1:0]        bjp_op1_i,
    input  logic [XLEN-1:0]        bjp_op2_i,
    input  logic [XLEN-1:0]        bjp_jump_op1_i,
    input  logic [XLEN-1:0]        bjp_jump_op2_i,

    output logic [XLEN-1:0]        inst_o,
    output logic [XLEN-1:0]        inst_addr_o,
    output logic [COMMIT_ID_W-1:0] commit_id_o,
    output logic                   reg_we_o,
    output logic [REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [XLEN-1:0]        alu_op1_o,
    output logic [XLEN-1:0]        alu_op2_o,
    output logic [ALU_OP_W-1:0]    alu_op_info_o,
    output logic [XLEN-1:0]        bjp_op1_o,
    output logic [XLEN-1:0]        bjp_op2_o,
    output logic [XLEN-1:0]        bjp_jump_op1_o,
    output logic [XLEN-1:0]        bjp_jump_op2_o
);

    // payload loads even on flush, the request bits gate its use
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_o         <= '0;
            inst_addr_o    <= '0;
            commit_id_o    <= '0;
            reg_we_o       <= 1'b0;
            reg_waddr_o    <= '0;
            alu_op1_o      <= '0;
            alu_op2_o      <= '0;
            alu_op_info_o  <= '0;
            bjp_op1_o      <= '0;
            bjp_op2_o      <= '0;
            bjp_jump_op1_o <= '0;
            bjp_jump_op2_o <= '0;
        end else if (upd_en_i) begin
            inst_o         <= inst_i;
            inst_addr_o    <= inst_addr_i;
            commit_id_o    <= commit_id_i;
            reg_we_o       <= reg_we_i;
            reg_waddr_o    <= reg_waddr_i;
            alu_op1_o      <= alu_op1_i;
            alu_op2_o      <= alu_op2_i;
            alu_op_info_o  <= alu_op_info_i;
            bjp_op1_o      <= bjp_op1_i;       // compare operands
            bjp_op2_o      <= bjp_op2_i;
            bjp_jump_op1_o <= bjp_jump_op1_i;  // target = op1 + op2
            bjp_jump_op2_o <= bjp_jump_op2_i;
        end
    end

endmodule

// File: src/dispatch_pipe.sv
// dispatch to execute pipeline register built from control, operand and memory slices
`timescale 1ns/1ns

module dispatch_pipe
    import dispatch_pkg::*;
#(
    parameter int COMMIT_ID_W = 3,
    parameter int MEM_DATA_W  = 64
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [CU_BUS_W-1:0]     stall_flag_i,     // flush / agu stall / dispatch stall

    input  logic                    inst_valid_i,
    input  logic [XLEN-1:0]         inst_i,
    input  logic [XLEN-1:0]         inst_addr_i,
    input  logic [COMMIT_ID_W-1:0]  commit_id_i,
    input  logic                    reg_we_i,
    input  logic [REG_ADDR_W-1:0]   reg_waddr_i,
    input  logic                    illegal_inst_i,
    input  logic                    req_alu_i,
    input  logic [XLEN-1:0]         alu_op1_i,
    input  logic [XLEN-1:0]         alu_op2_i,
    input  logic [ALU_OP_W-1:0]     alu_op_info_i,
    input  logic                    req_bjp_i,
    input  logic [XLEN-1:0]         bjp_op1_i,
    input  logic [XLEN-1:0]         bjp_op2_i,
    input  logic [XLEN-1:0]         bjp_jump_op1_i,
    input  logic [XLEN-1:0]         bjp_jump_op2_i,
    input  logic                    req_mem_i,
    input  logic [XLEN-1:0]         mem_addr_i,
    input  logic [MEM_DATA_W/8-1:0] mem_wmask_i,
    input  logic [MEM_DATA_W-1:0]   mem_wdata_i,
    input  logic [COMMIT_ID_W-1:0]  mem_commit_id_i,
    input  logic [REG_ADDR_W-1:0]   mem_reg_waddr_i,
    input  logic                    misaligned_load_i,
    input  logic                    misaligned_store_i,
    input  fu_op_u                  fu_op_i,
    input  logic [SYS_OP_W-1:0]     sys_op_i,

    output logic                    inst_valid_o,
    output logic [XLEN-1:0]         inst_o,
    output logic [XLEN-1:0]         inst_addr_o,
    output logic [COMMIT_ID_W-1:0]  commit_id_o,
    output logic                    reg_we_o,
    output logic [REG_ADDR_W-1:0]   reg_waddr_o,
    output logic                    illegal_inst_o,
    output logic                    req_alu_o,
    output logic [XLEN-1:0]         alu_op1_o,
    output logic [XLEN-1:0]         alu_op2_o,
    output logic [ALU_OP_W-1:0]     alu_op_info_o,
    output logic                    req_bjp_o,
    output logic [XLEN-1:0]         bjp_op1_o,
    output logic [XLEN-1:0]         bjp_op2_o,
    output logic [XLEN-1:0]         bjp_jump_op1_o,
    output logic [XLEN-1:0]         bjp_jump_op2_o,
    output logic                    req_mem_o,
    output logic [XLEN-1:0]         mem_addr_o,
    output logic [MEM_DATA_W/8-1:0] mem_wmask_o,
    output logic [MEM_DATA_W-1:0]   mem_wdata_o,
    output logic [COMMIT_ID_W-1:0]  mem_commit_id_o,
    output logic [REG_ADDR_W-1:0]   mem_reg_waddr_o,
    output logic                    misaligned_load_o,
    output logic                    misaligned_store_o,
    output fu_op_u                  fu_op_o,
    output logic [SYS_OP_W-1:0]     sys_op_o
);

    logic upd_en;  // high while dispatch is not stalled

    dispatch_ctrl_regs u_ctrl_regs (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .stall_flag_i       (stall_flag_i),
        .inst_valid_i       (inst_valid_i),
        .req_alu_i          (req_alu_i),
        .req_bjp_i          (req_bjp_i),
        .req_mem_i          (req_mem_i),
        .illegal_inst_i     (illegal_inst_i),
        .misaligned_load_i  (misaligned_load_i),
        .misaligned_store_i (misaligned_store_i),
        .sys_op_i           (sys_op_i),
        .upd_en_o           (upd_en),
        .inst_valid_o       (inst_valid_o),
        .req_alu_o          (req_alu_o),
        .req_bjp_o          (req_bjp_o),
        .req_mem_o          (req_mem_o),
        .illegal_inst_o     (illegal_inst_o),
        .misaligned_load_o  (misaligned_load_o),
        .misaligned_store_o (misaligned_store_o),
        .sys_op_o           (sys_op_o)
    );

    // payload slices only see the update enable
    dispatch_operand_regs #(
        .COMMIT_ID_W (COMMIT_ID_W)
    ) u_operand_regs (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .upd_en_i       (upd_en),
        .inst_i         (inst_i),
        .inst_addr_i    (inst_addr_i),
        .commit_id_i    (commit_id_i),
        .reg_we_i       (reg_we_i),
        .reg_waddr_i    (reg_waddr_i),
        .alu_op1_i      (alu_op1_i),
        .alu_op2_i      (alu_op2_i),
        .alu_op_info_i  (alu_op_info_i),
        .bjp_op1_i      (bjp_op1_i),
        .bjp_op2_i      (bjp_op2_i),
        .bjp_jump_op1_i (bjp_jump_op1_i),
        .bjp_jump_op2_i (bjp_jump_op2_i),
        .inst_o         (inst_o),
        .inst_addr_o    (inst_addr_o),
        .commit_id_o    (commit_id_o),
        .reg_we_o       (reg_we_o),
        .reg_waddr_o    (reg_waddr_o),
        .alu_op1_o      (alu_op1_o),
        .alu_op2_o      (alu_op2_o),
        .alu_op_info_o  (alu_op_info_o),
        .bjp_op1_o      (bjp_op1_o),
        .bjp_op2_o      (bjp_op2_o),
        .bjp_jump_op1_o (bjp_jump_op1_o),
        .bjp_jump_op2_o (bjp_jump_op2_o)
    );

    dispatch_mem_regs #(
        .COMMIT_ID_W (COMMIT_ID_W),
        .MEM_DATA_W  (MEM_DATA_W)
    ) u_mem_regs (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .upd_en_i        (upd_en),
        .mem_addr_i      (mem_addr_i),
        .mem_wmask_i     (mem_wmask_i),
        .mem_wdata_i     (mem_wdata_i),
        .mem_commit_id_i (mem_commit_id_i),
        .mem_reg_waddr_i (mem_reg_waddr_i),
        .fu_op_i         (fu_op_i),
        .mem_addr_o      (mem_addr_o),
        .mem_wmask_o     (mem_wmask_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_commit_id_o (mem_commit_id_o),
        .mem_reg_waddr_o (mem_reg_waddr_o),
        .fu_op_o         (fu_op_o)
    );

endmodule

// File: src/dispatch_pkg.sv
// widths, stall flag bit positions, sys-op indices and the shared bjp/mem op word
package dispatch_pkg;

    localparam int XLEN       = 32;  // machine word
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;

    // stall flag bus from the control unit
    localparam int CU_BUS_W          = 4;
    localparam int CU_FLUSH          = 0;
    localparam int CU_STALL_AGU      = 1;
    localparam int CU_STALL_DISPATCH = 2;

    // one bit per system op
    localparam int SYS_OP_W   = 6;
    localparam int SYS_NOP    = 0;  // only bit that survives a flush
    localparam int SYS_MRET   = 1;
    localparam int SYS_ECALL  = 2;
    localparam int SYS_EBREAK = 3;
    localparam int SYS_FENCE  = 4;
    localparam int SYS_DRET   = 5;

    typedef struct packed {
        logic jal;
        logic beq;
        logic bne;
        logic blt;
        logic bltu;
        logic bge;
        logic bgeu;
        logic jalr;
    } bjp_op_t;

    typedef struct packed {
        logic lb;
        logic lh;
        logic lw;
        logic lbu;
        logic lhu;
        logic load;
        logic store;
        logic spare;
    } mem_op_t;

    // bjp and mem requests never overlap, so they share one op word
    typedef union packed {
        bjp_op_t bjp;
        mem_op_t mem;
    } fu_op_u;

endpackage

// File: testbench/dispatch_cases.txt
// per line one hex word: stall flags, {valid alu bjp mem}, op word (2 digits), sys ops (2), {0 illegal misload misstore}
// stall flags are bit 0 flush, bit 1 agu stall, bit 2 dispatch stall
0C00000
0A80000
0924000
0C00000
0A40000
0922000
0800010
0800040
1C00044
2924002
1800030
0A20000
4C00000
4924000
5A80010
6C00081
0922001
0800100
0800200
0800004
3A013F7
0C00000
0A02000
0914000
4000000
0000000

// File: testbench/tb_dispatch_pipe.sv
// dispatch pipeline testbench with case file stimulus, reference model, checks and watchdog
`timescale 1ns/1ns

module tb_dispatch_pipe
    import dispatch_pkg::*;
();

    localparam int          COMMIT_ID_W = 3;
    localparam int          MEM_DATA_W  = 64;
    localparam int          MAX_CASES   = 64;
    localparam logic [31:0] END_MARK    = 32'hffff_ffff;  // marks slots past the last case

    logic                    clk = 1'b0;
    logic                    rst_n_i;
    logic [CU_BUS_W-1:0]     stall_flag_i;

    logic                    inst_valid_i, reg_we_i, illegal_inst_i;
    logic                    req_alu_i, req_bjp_i, req_mem_i;
    logic                    misaligned_load_i, misaligned_store_i;
    logic [XLEN-1:0]         inst_i, inst_addr_i, alu_op1_i, alu_op2_i, mem_addr_i;
    logic [XLEN-1:0]         bjp_op1_i, bjp_op2_i, bjp_jump_op1_i, bjp_jump_op2_i;
    logic [COMMIT_ID_W-1:0]  commit_id_i, mem_commit_id_i;
    logic [REG_ADDR_W-1:0]   reg_waddr_i, mem_reg_waddr_i;
    logic [ALU_OP_W-1:0]     alu_op_info_i;
    logic [MEM_DATA_W/8-1:0] mem_wmask_i;
    logic [MEM_DATA_W-1:0]   mem_wdata_i;
    fu_op_u                  fu_op_i;
    logic [SYS_OP_W-1:0]     sys_op_i;

    logic                    inst_valid_o, reg_we_o, illegal_inst_o;
    logic                    req_alu_o, req_bjp_o, req_mem_o;
    logic                    misaligned_load_o, misaligned_store_o;
    logic [XLEN-1:0]         inst_o, inst_addr_o, alu_op1_o, alu_op2_o, mem_addr_o;
    logic [XLEN-1:0]         bjp_op1_o, bjp_op2_o, bjp_jump_op1_o, bjp_jump_op2_o;
    logic [COMMIT_ID_W-1:0]  commit_id_o, mem_commit_id_o;
    logic [REG_ADDR_W-1:0]   reg_waddr_o, mem_reg_waddr_o;
    logic [ALU_OP_W-1:0]     alu_op_info_o;
    logic [MEM_DATA_W/8-1:0] mem_wmask_o;
    logic [MEM_DATA_W-1:0]   mem_wdata_o;
    fu_op_u                  fu_op_o;
    logic [SYS_OP_W-1:0]     sys_op_o;

    // reference model state the outputs must show after the next edge
    logic [6:0]                                                 exp_ctrl;
    logic [SYS_OP_W-1:0]                                        exp_sys;
    logic [7:0]                                                 exp_op;
    logic [2*XLEN+COMMIT_ID_W+REG_ADDR_W:0]                     exp_info;
    logic [2*XLEN+ALU_OP_W-1:0]                                 exp_alu;
    logic [4*XLEN-1:0]                                          exp_bjp;
    logic [XLEN+MEM_DATA_W/8+MEM_DATA_W+COMMIT_ID_W+REG_ADDR_W-1:0] exp_mem;

    logic [31:0] cases [0:MAX_CASES-1];
    int          n_cases;
    int          test_errs = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    logic        loaded = 1'b0;

    dispatch_pipe #(
        .COMMIT_ID_W (COMMIT_ID_W),
        .MEM_DATA_W  (MEM_DATA_W)
    ) dut (.*);

    always #5 clk = ~clk;

    task automatic clear_inputs();
        stall_flag_i = '0;
        {inst_valid_i, req_alu_i, req_bjp_i, req_mem_i} = '0;
        {illegal_inst_i, misaligned_load_i, misaligned_store_i, reg_we_i} = '0;
        {inst_i, inst_addr_i, commit_id_i, reg_waddr_i} = '0;
        {alu_op1_i, alu_op2_i, alu_op_info_i} = '0;
        {bjp_op1_i, bjp_op2_i, bjp_jump_op1_i, bjp_jump_op2_i} = '0;
        {mem_addr_i, mem_wmask_i, mem_wdata_i, mem_commit_id_i, mem_reg_waddr_i} = '0;
        fu_op_i  = '0;
        sys_op_i = '0;
    endtask

    // case word layout stall[27:24] {valid alu bjp mem}[23:20] op[19:12] sys[9:4] exc[2:0]
    task automatic apply_case(input logic [31:0] c);
        logic kill;
        stall_flag_i = c[27:24];
        {inst_valid_i, req_alu_i, req_bjp_i, req_mem_i} = c[23:20];
        fu_op_i  = c[19:12];
        sys_op_i = c[9:4];
        {illegal_inst_i, misaligned_load_i, misaligned_store_i} = c[2:0];
        inst_i          = $urandom();
        inst_addr_i     = $urandom();
        commit_id_i     = COMMIT_ID_W'($urandom());
        reg_we_i        = 1'($urandom());
        reg_waddr_i     = REG_ADDR_W'($urandom());
        alu_op1_i       = $urandom();
        alu_op2_i       = $urandom();
        alu_op_info_i   = ALU_OP_W'($urandom());
        bjp_op1_i       = $urandom();
        bjp_op2_i       = $urandom();
        bjp_jump_op1_i  = $urandom();
        bjp_jump_op2_i  = $urandom();
        mem_addr_i      = $urandom();
        mem_wmask_i     = (MEM_DATA_W/8)'($urandom());
        mem_wdata_i     = {$urandom(), $urandom()};
        mem_commit_id_i = COMMIT_ID_W'($urandom());
        mem_reg_waddr_i = REG_ADDR_W'($urandom());
        // a dispatch stall freezes the whole stage including flush
        if (!stall_flag_i[CU_STALL_DISPATCH]) begin
            kill     = stall_flag_i[CU_FLUSH] | stall_flag_i[CU_STALL_AGU];
            exp_ctrl = {inst_valid_i, req_alu_i, req_bjp_i, req_mem_i, illegal_inst_i,
                        misaligned_load_i, misaligned_store_i} & {7{~kill}};
            exp_sys  = kill ? '0 : sys_op_i;
            exp_sys[SYS_NOP] = sys_op_i[SYS_NOP];  // nop survives a kill
            exp_op   = fu_op_i;
            exp_info = {inst_i, inst_addr_i, commit_id_i, reg_we_i, reg_waddr_i};
            exp_alu  = {alu_op1_i, alu_op2_i, alu_op_info_i};
            exp_bjp  = {bjp_op1_i, bjp_op2_i, bjp_jump_op1_i, bjp_jump_op2_i};
            exp_mem  = {mem_addr_i, mem_wmask_i, mem_wdata_i, mem_commit_id_i,
                        mem_reg_waddr_i};
        end
    endtask

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_outputs();
        check_val("control bits", 128'({inst_valid_o, req_alu_o, req_bjp_o, req_mem_o,
                  illegal_inst_o, misaligned_load_o, misaligned_store_o}), 128'(exp_ctrl));
        check_val("sys_op_o", 128'(sys_op_o), 128'(exp_sys));
        check_val("inst info", 128'({inst_o, inst_addr_o, commit_id_o, reg_we_o,
                  reg_waddr_o}), 128'(exp_info));
        check_val("alu operands", 128'({alu_op1_o, alu_op2_o, alu_op_info_o}), 128'(exp_alu));
        check_val("bjp operands", {bjp_op1_o, bjp_op2_o, bjp_jump_op1_o, bjp_jump_op2_o},
                  exp_bjp);
        check_val("mem access", 128'({mem_addr_o, mem_wmask_o, mem_wdata_o, mem_commit_id_o,
                  mem_reg_waddr_o}), 128'(exp_mem));
        // op word read field by field through each view with jal and lb on top
        check_val("op word bjp view", 128'({fu_op_o.bjp.jal, fu_op_o.bjp.beq, fu_op_o.bjp.bne,
                  fu_op_o.bjp.blt, fu_op_o.bjp.bltu, fu_op_o.bjp.bge, fu_op_o.bjp.bgeu,
                  fu_op_o.bjp.jalr}), 128'(exp_op));
        check_val("op word mem view", 128'({fu_op_o.mem.lb, fu_op_o.mem.lh, fu_op_o.mem.lw,
                  fu_op_o.mem.lbu, fu_op_o.mem.lhu, fu_op_o.mem.load, fu_op_o.mem.store,
                  fu_op_o.mem.spare}), 128'(exp_op));
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: pass", name);
            n_pass++;
        end else begin
            $display("test %s: FAIL with %0d mismatches", name, test_errs);
            n_fail++;
        end
        test_errs = 0;
    endtask

    initial begin
        int i;
        clear_inputs();
        rst_n_i = 1'b0;
        void'($urandom(94394));
        for (i = 0; i < MAX_CASES; i++) begin
            cases[i] = END_MARK;
        end
        $readmemh("testbench/dispatch_cases.txt", cases);
        n_cases = 0;
        while (n_cases < MAX_CASES && cases[n_cases] != END_MARK) begin
            n_cases++;
        end
        loaded = 1'b1;
        if (n_cases == 0) begin
            $display("no cases could be read from the case file");
            n_fail++;
        end

        repeat (8) @(posedge clk);
        #1;
        rst_n_i  = 1'b1;
        exp_ctrl = '0;  // everything starts cleared
        exp_sys  = '0;
        exp_op   = '0;
        exp_info = '0;
        exp_alu  = '0;
        exp_bjp  = '0;
        exp_mem  = '0;
        check_outputs();
        finish_test("reset");

        for (i = 0; i < n_cases; i++) begin
            apply_case(cases[i]);
            @(posedge clk);
            #1;
            check_outputs();
            finish_test($sformatf("case %0d stall %h", i, cases[i][27:24]));
        end

        $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog sized from the case count
    initial begin
        wait (loaded);
        #((n_cases + 20) * 10);
        $display("Timeout: the run was still going after %0d clock cycles", n_cases + 20);
        $display("Something failed");
        $finish;
    end

endmodule
